// File: sim.f
src/dlx_pkg.sv
src/reg_file.sv
src/alu.sv
src/decode.sv
src/execute.sv
src/dlx_core.sv
test/dlx_core_sva.sv
test/dlx_core_tb.sv

// File: src/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  logic [0:31]        a,
    input  logic [0:31]        b,
    input  dlx_pkg::alu_ctrl_t ctrl,
    output logic [0:31]        result,
    output logic               zero
);

    import dlx_pkg::*;

    logic [0:4] shamt;

    assign shamt = b[27:31];        // low five bits

    always_comb begin
        case (ctrl)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_and: result = a & b;
            alu_or:  result = a | b;
            alu_xor: result = a ^ b;
            alu_sll: result = a << shamt;
            alu_srl: result = a >> shamt;
            alu_sra: result = $signed(a) >>> shamt;
            alu_slt: result = {31'd0, $signed(a) < $signed(b)};
            alu_mul: result = a * b;    // low word of the product
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

`default_nettype wire

// File: src/decode.sv
`timescale 1ns/100ps
`default_nettype none

module decode #(
    parameter int reg_count = 32
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    output logic               in_ready,
    input  dlx_pkg::instr_t    instr,
    input  logic [0:31]        next_pc,
    output logic [0:4]         reg_a_addr,
    output logic [0:4]         reg_b_addr,
    input  logic [0:31]        reg_a_data,
    input  logic [0:31]        reg_b_data,
    output logic               dec_valid,
    input  logic               dec_ready,
    output logic [0:31]        dec_next_pc,
    output logic [0:31]        dec_op_a,
    output logic [0:31]        dec_op_b,
    output logic [0:31]        dec_imm16,
    output logic [0:31]        dec_imm26,
    output logic [0:4]         dec_dest_reg,
    output dlx_pkg::alu_ctrl_t dec_alu_ctrl,
    output logic               dec_pc_to_reg,
    output logic               dec_reg_to_pc,
    output logic               dec_jump,
    output logic               dec_branch,
    output logic               dec_branch_zero,
    output logic               dec_reg_write,
    input  logic [0:4]         ex_busy_reg,
    input  logic               ex_busy_write
);

    import dlx_pkg::*;

    logic [0:31] imm16, imm26;
    logic [0:4]  nxt_dest;
    alu_ctrl_t   nxt_ctrl;
    logic        use_imm;
    logic        nxt_pc_to_reg, nxt_reg_to_pc, nxt_jump;
    logic        nxt_branch, nxt_branch_zero, nxt_reg_write;
    logic        hit_a, hit_b, load;

    assign imm16 = {{16{instr.i.offset[0]}}, instr.i.offset};
    assign imm26 = {{6{instr.i.rs1[0]}}, instr.i.rs1, instr.i.rd, instr.i.offset};

    always_comb begin
        reg_a_addr      = instr.i.rs1;
        reg_b_addr      = 5'd0;     // reads zero unless r-type
        nxt_dest        = instr.i.rd;
        nxt_ctrl        = alu_add;
        use_imm         = 1'b0;
        nxt_pc_to_reg   = 1'b0;
        nxt_reg_to_pc   = 1'b0;
        nxt_jump        = 1'b0;
        nxt_branch      = 1'b0;
        nxt_branch_zero = 1'b0;
        nxt_reg_write   = 1'b0;
        case (instr.r.opcode)
            op_rtype: begin
                reg_b_addr    = instr.r.rs2;
                nxt_dest      = instr.r.rd;
                nxt_reg_write = 1'b1;
                case (instr.r.funct)
                    fn_add:  nxt_ctrl = alu_add;
                    fn_sub:  nxt_ctrl = alu_sub;
                    fn_and:  nxt_ctrl = alu_and;
                    fn_or:   nxt_ctrl = alu_or;
                    fn_xor:  nxt_ctrl = alu_xor;
                    fn_sll:  nxt_ctrl = alu_sll;
                    fn_srl:  nxt_ctrl = alu_srl;
                    fn_sra:  nxt_ctrl = alu_sra;
                    fn_slt:  nxt_ctrl = alu_slt;
                    fn_mul:  nxt_ctrl = alu_mul;
                    default: nxt_reg_write = 1'b0;
                endcase
            end
            op_addi, op_andi, op_ori, op_xori, op_slti: begin
                use_imm       = 1'b1;
                nxt_reg_write = 1'b1;
                case (instr.i.opcode)
                    op_andi: nxt_ctrl = alu_and;
                    op_ori:  nxt_ctrl = alu_or;
                    op_xori: nxt_ctrl = alu_xor;
                    op_slti: nxt_ctrl = alu_slt;
                    default: nxt_ctrl = alu_add;
                endcase
            end
            op_beqz: begin
                nxt_branch      = 1'b1;
                nxt_branch_zero = 1'b1;
            end
            op_bnez: nxt_branch = 1'b1;
            op_j: begin
                reg_a_addr = 5'd0;
                nxt_jump   = 1'b1;
            end
            op_jal: begin
                reg_a_addr    = 5'd0;
                nxt_jump      = 1'b1;
                nxt_pc_to_reg = 1'b1;
                nxt_reg_write = 1'b1;
                nxt_dest      = LINK_REG;
            end
            op_jr: begin
                nxt_jump      = 1'b1;
                nxt_reg_to_pc = 1'b1;
            end
            op_jalr: begin
                nxt_jump      = 1'b1;
                nxt_reg_to_pc = 1'b1;
                nxt_pc_to_reg = 1'b1;
                nxt_reg_write = 1'b1;
                nxt_dest      = LINK_REG;
            end
            default: reg_a_addr = 5'd0;
        endcase
    end

    // scoreboard against the two instructions in flight
    always_comb begin
        hit_a = reg_a_addr != 5'd0 && reg_a_addr < reg_count &&
                ((dec_valid && dec_reg_write && reg_a_addr == dec_dest_reg) ||
                 (ex_busy_write && reg_a_addr == ex_busy_reg));
        hit_b = reg_b_addr != 5'd0 && reg_b_addr < reg_count &&
                ((dec_valid && dec_reg_write && reg_b_addr == dec_dest_reg) ||
                 (ex_busy_write && reg_b_addr == ex_busy_reg));
    end

    assign in_ready = in_valid && !hit_a && !hit_b && (!dec_valid || dec_ready);
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid       <= 1'b0;
            dec_pc_to_reg   <= 1'b0;
            dec_reg_to_pc   <= 1'b0;
            dec_jump        <= 1'b0;
            dec_branch      <= 1'b0;
            dec_branch_zero <= 1'b0;
            dec_reg_write   <= 1'b0;
        end else begin
            if (!dec_valid || dec_ready)
                dec_valid <= load;
            if (load) begin
                dec_pc_to_reg   <= nxt_pc_to_reg;
                dec_reg_to_pc   <= nxt_reg_to_pc;
                dec_jump        <= nxt_jump;
                dec_branch      <= nxt_branch;
                dec_branch_zero <= nxt_branch_zero;
                dec_reg_write   <= nxt_reg_write;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            dec_next_pc  <= next_pc;
            dec_op_a     <= reg_a_data;
            dec_op_b     <= use_imm ? imm16 : reg_b_data;
            dec_imm16    <= imm16;
            dec_imm26    <= imm26;
            dec_dest_reg <= nxt_dest;
            dec_alu_ctrl <= nxt_ctrl;
        end
    end

endmodule

`default_nettype wire

// File: src/dlx_core.sv
`timescale 1ns/100ps
`default_nettype none

module dlx_core #(
    parameter int reg_count = 32
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    output logic            in_ready,
    input  dlx_pkg::instr_t instr,
    input  logic [0:31]     next_pc,
    output logic            res_valid,
    input  logic            res_ready,
    output logic [0:31]     alu_result,
    output logic            leap,
    output logic [0:31]     leap_addr,
    output logic [0:4]      dest_reg,
    output logic            reg_write
);

    import dlx_pkg::*;

    logic [0:4]  reg_a_addr, reg_b_addr;
    logic [0:31] reg_a_data, reg_b_data;
    logic        dec_valid, dec_ready;
    logic [0:31] dec_next_pc, dec_op_a, dec_op_b, dec_imm16, dec_imm26;
    logic [0:4]  dec_dest_reg;
    alu_ctrl_t   dec_alu_ctrl;
    logic        dec_pc_to_reg, dec_reg_to_pc, dec_jump;
    logic        dec_branch, dec_branch_zero, dec_reg_write;
    logic [0:4]  ex_busy_reg;
    logic        ex_busy_write;
    logic        wb_en;
    logic [0:4]  wb_addr;
    logic [0:31] wb_data;

    // retire into the register file on the output transfer
    assign wb_en   = res_valid && res_ready && reg_write;
    assign wb_addr = dest_reg;
    assign wb_data = alu_result;

    reg_file #(.reg_count(reg_count)) u_reg_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_addr_a (reg_a_addr),
        .rd_addr_b (reg_b_addr),
        .wr_en     (wb_en),
        .wr_addr   (wb_addr),
        .wr_data   (wb_data),
        .rd_data_a (reg_a_data),
        .rd_data_b (reg_b_data)
    );

    decode #(.reg_count(reg_count)) u_decode (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .in_ready        (in_ready),
        .instr           (instr),
        .next_pc         (next_pc),
        .reg_a_addr      (reg_a_addr),
        .reg_b_addr      (reg_b_addr),
        .reg_a_data      (reg_a_data),
        .reg_b_data      (reg_b_data),
        .dec_valid       (dec_valid),
        .dec_ready       (dec_ready),
        .dec_next_pc     (dec_next_pc),
        .dec_op_a        (dec_op_a),
        .dec_op_b        (dec_op_b),
        .dec_imm16       (dec_imm16),
        .dec_imm26       (dec_imm26),
        .dec_dest_reg    (dec_dest_reg),
        .dec_alu_ctrl    (dec_alu_ctrl),
        .dec_pc_to_reg   (dec_pc_to_reg),
        .dec_reg_to_pc   (dec_reg_to_pc),
        .dec_jump        (dec_jump),
        .dec_branch      (dec_branch),
        .dec_branch_zero (dec_branch_zero),
        .dec_reg_write   (dec_reg_write),
        .ex_busy_reg     (ex_busy_reg),
        .ex_busy_write   (ex_busy_write)
    );

    execute u_execute (
        .clk             (clk),
        .rst_n           (rst_n),
        .dec_valid       (dec_valid),
        .dec_ready       (dec_ready),
        .dec_next_pc     (dec_next_pc),
        .dec_op_a        (dec_op_a),
        .dec_op_b        (dec_op_b),
        .dec_imm16       (dec_imm16),
        .dec_imm26       (dec_imm26),
        .dec_dest_reg    (dec_dest_reg),
        .dec_alu_ctrl    (dec_alu_ctrl),
        .dec_pc_to_reg   (dec_pc_to_reg),
        .dec_reg_to_pc   (dec_reg_to_pc),
        .dec_jump        (dec_jump),
        .dec_branch      (dec_branch),
        .dec_branch_zero (dec_branch_zero),
        .dec_reg_write   (dec_reg_write),
        .ex_busy_reg     (ex_busy_reg),
        .ex_busy_write   (ex_busy_write),
        .res_valid       (res_valid),
        .res_ready       (res_ready),
        .alu_result      (alu_result),
        .leap            (leap),
        .leap_addr       (leap_addr),
        .dest_reg        (dest_reg),
        .reg_write       (reg_write)
    );

endmodule

`default_nettype wire

// File: src/dlx_pkg.sv
`default_nettype none

package dlx_pkg;

    typedef enum logic [0:5] {
        op_rtype = 6'h00,
        op_j     = 6'h02,
        op_jal   = 6'h03,
        op_beqz  = 6'h04,
        op_bnez  = 6'h05,
        op_addi  = 6'h08,
        op_slti  = 6'h0a,
        op_andi  = 6'h0c,
        op_ori   = 6'h0d,
        op_xori  = 6'h0e,
        op_jr    = 6'h12,
        op_jalr  = 6'h13
    } opcode_t;

    typedef enum logic [0:5] {
        fn_sll = 6'h04,
        fn_srl = 6'h06,
        fn_sra = 6'h07,
        fn_mul = 6'h0e,
        fn_add = 6'h20,
        fn_sub = 6'h22,
        fn_and = 6'h24,
        fn_or  = 6'h25,
        fn_xor = 6'h26,
        fn_slt = 6'h2a
    } funct_t;

    typedef enum logic [0:3] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_xor = 4'd4,
        alu_sll = 4'd5,
        alu_srl = 4'd6,
        alu_sra = 4'd7,
        alu_slt = 4'd8,
        alu_mul = 4'd9
    } alu_ctrl_t;

    // bit 0 is the msb, opcode sits in the top six bits of both views
    typedef union packed {
        struct packed {
            opcode_t    opcode;
            logic [0:4] rs1;
            logic [0:4] rs2;
            logic [0:4] rd;
            logic [0:4] shamt;
            funct_t     funct;
        } r;
        struct packed {
            opcode_t     opcode;
            logic [0:4]  rs1;       // jump offset spans rs1, rd and offset
            logic [0:4]  rd;
            logic [0:15] offset;
        } i;
    } instr_t;

    localparam logic [0:4] LINK_REG = 5'd31;

endpackage

`default_nettype wire

// File: src/execute.sv
`timescale 1ns/100ps
`default_nettype none

module execute (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               dec_valid,
    output logic               dec_ready,
    input  logic [0:31]        dec_next_pc,
    input  logic [0:31]        dec_op_a,
    input  logic [0:31]        dec_op_b,
    input  logic [0:31]        dec_imm16,
    input  logic [0:31]        dec_imm26,
    input  logic [0:4]         dec_dest_reg,
    input  dlx_pkg::alu_ctrl_t dec_alu_ctrl,
    input  logic               dec_pc_to_reg,
    input  logic               dec_reg_to_pc,
    input  logic               dec_jump,
    input  logic               dec_branch,
    input  logic               dec_branch_zero,
    input  logic               dec_reg_write,
    output logic [0:4]         ex_busy_reg,
    output logic               ex_busy_write,
    output logic               res_valid,
    input  logic               res_ready,
    output logic [0:31]        alu_result,
    output logic               leap,
    output logic [0:31]        leap_addr,
    output logic [0:4]         dest_reg,
    output logic               reg_write
);

    logic [0:31] alu_out;
    logic        alu_zero;
    logic        take;
    logic [0:31] target;
    logic [0:31] nxt_result;
    logic        load;

    alu u_alu (
        .a      (dec_op_a),
        .b      (dec_op_b),
        .ctrl   (dec_alu_ctrl),
        .result (alu_out),
        .zero   (alu_zero)
    );

    // branches see op_a + 0, so the zero flag tests op_a
    assign take   = dec_jump || (dec_branch && (alu_zero == dec_branch_zero));
    assign target = dec_reg_to_pc ? dec_op_a
                  : dec_next_pc + (dec_branch ? dec_imm16 : dec_imm26);
    assign nxt_result = dec_pc_to_reg ? dec_next_pc : alu_out;   // link value

    assign dec_ready = !res_valid || res_ready;
    assign load      = dec_valid && dec_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
            leap      <= 1'b0;
            reg_write <= 1'b0;
        end else if (dec_ready) begin
            res_valid <= dec_valid;
            if (dec_valid) begin
                leap      <= take;
                reg_write <= dec_reg_write;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            alu_result <= nxt_result;
            leap_addr  <= target;
            dest_reg   <= dec_dest_reg;
        end
    end

    // destination still owed to the register file
    assign ex_busy_reg   = dest_reg;
    assign ex_busy_write = res_valid && reg_write;

endmodule

`default_nettype wire

// File: src/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file #(
    parameter int reg_count = 32
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [0:4]  rd_addr_a,
    input  logic [0:4]  rd_addr_b,
    input  logic        wr_en,
    input  logic [0:4]  wr_addr,
    input  logic [0:31] wr_data,
    output logic [0:31] rd_data_a,
    output logic [0:31] rd_data_b
);

    logic [0:31] mem [0:reg_count-1];

    // register 0 and addresses past the end read as zero
    function automatic logic [0:31] read_port(input logic [0:4] addr);
        if (addr == 5'd0 || addr >= reg_count)
            return '0;
        if (wr_en && wr_addr == addr)
            return wr_data;         // value retiring this cycle
        return mem[addr];
    endfunction

    always_comb begin
        rd_data_a = read_port(rd_addr_a);
        rd_data_b = read_port(rd_addr_b);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_count; i++)
                mem[i] <= '0;
        end else if (wr_en && wr_addr != 5'd0 && wr_addr < reg_count) begin
            mem[wr_addr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// File: test/dlx_core_sva.sv
`timescale 1ns/100ps
`default_nettype none

module dlx_core_sva (
    input logic        clk,
    input logic        rst_n,
    input logic        in_valid,
    input logic        in_ready,
    input logic [0:31] instr,
    input logic [0:31] next_pc,
    input logic        res_valid,
    input logic        res_ready,
    input logic [0:31] alu_result,
    input logic        leap,
    input logic [0:31] leap_addr,
    input logic [0:4]  dest_reg,
    input logic        reg_write
);

    int fail_count = 0;

    quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> !res_valid && !leap && !reg_write)
        else begin
            fail_count++;
            $error("output strobes active while reset is held");
        end

    hold_result: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid && !res_ready |=> res_valid && $stable(alu_result) && $stable(leap)
            && $stable(leap_addr) && $stable(dest_reg) && $stable(reg_write))
        else begin
            fail_count++;
            $error("result changed before it was accepted");
        end

    hold_request: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && !in_ready |=> in_valid && $stable(instr) && $stable(next_pc))
        else begin
            fail_count++;
            $error("stalled instruction changed before it was taken");
        end

endmodule

bind dlx_core dlx_core_sva sva_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .instr      (instr),
    .next_pc    (next_pc),
    .res_valid  (res_valid),
    .res_ready  (res_ready),
    .alu_result (alu_result),
    .leap       (leap),
    .leap_addr  (leap_addr),
    .dest_reg   (dest_reg),
    .reg_write  (reg_write)
);

`default_nettype wire

// File: test/dlx_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module dlx_core_tb;

    import dlx_pkg::*;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic        in_ready;
    instr_t      instr;
    logic [0:31] next_pc;
    logic        res_valid;
    logic        res_ready;
    logic [0:31] alu_result;
    logic        leap;
    logic [0:31] leap_addr;
    logic [0:4]  dest_reg;
    logic        reg_write;

    integer      seed = 32'hdbafc50f;
    int          errors;
    int          received;
    int          prog_len = 0;
    instr_t      prog [$];
    logic [0:31] npcs [$];
    int          gaps [$];
    logic [0:31] model_regs [0:31];
    logic [0:31] exp_result [$];
    logic [0:31] exp_addr [$];
    logic [0:4]  exp_dest [$];
    logic        exp_leap [$];
    logic        exp_flow [$];
    logic        exp_write [$];

    dlx_core uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .instr      (instr),
        .next_pc    (next_pc),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .alu_result (alu_result),
        .leap       (leap),
        .leap_addr  (leap_addr),
        .dest_reg   (dest_reg),
        .reg_write  (reg_write)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic instr_t rword(input funct_t fn, input logic [0:4] rd,
                                     input logic [0:4] rs1, input logic [0:4] rs2);
        instr_t w;
        w          = '0;
        w.r.opcode = op_rtype;
        w.r.rs1    = rs1;
        w.r.rs2    = rs2;
        w.r.rd     = rd;
        w.r.funct  = fn;
        return w;
    endfunction

    function automatic instr_t iword(input opcode_t op, input logic [0:4] rd,
                                     input logic [0:4] rs1, input logic [0:15] imm);
        instr_t w;
        w          = '0;
        w.i.opcode = op;
        w.i.rs1    = rs1;
        w.i.rd     = rd;
        w.i.offset = imm;
        return w;
    endfunction

    function automatic instr_t jword(input opcode_t op, input logic [0:25] off);
        instr_t w;
        w          = '0;
        w.i.opcode = op;
        {w.i.rs1, w.i.rd, w.i.offset} = off;
        return w;
    endfunction

    // program-order reference, one expected transfer per instruction
    function automatic void model_step(input instr_t w, input logic [0:31] npc);
        logic [0:31] a, b, sx16, sx26, res, addr;
        logic        lp, flow, wr;
        logic [0:4]  dst;
        a    = model_regs[w.r.rs1];
        b    = model_regs[w.r.rs2];
        sx16 = 32'($signed(w.i.offset));
        sx26 = 32'($signed({w.i.rs1, w.i.rd, w.i.offset}));
        res  = '0;
        addr = '0;
        lp   = 1'b0;
        flow = 1'b0;
        wr   = 1'b1;
        dst  = w.i.rd;
        case (w.r.opcode)
            op_rtype: begin
                dst = w.r.rd;
                case (w.r.funct)
                    fn_add:  res = a + b;
                    fn_sub:  res = a - b;
                    fn_and:  res = a & b;
                    fn_or:   res = a | b;
                    fn_xor:  res = a ^ b;
                    fn_sll:  res = a << b[27:31];
                    fn_srl:  res = a >> b[27:31];
                    fn_sra:  res = $signed(a) >>> b[27:31];
                    fn_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    fn_mul:  res = a * b;
                    default: wr = 1'b0;
                endcase
            end
            op_addi: res = a + sx16;
            op_andi: res = a & sx16;
            op_ori:  res = a | sx16;
            op_xori: res = a ^ sx16;
            op_slti: res = ($signed(a) < $signed(sx16)) ? 32'd1 : 32'd0;
            op_beqz, op_bnez: begin
                wr   = 1'b0;
                flow = 1'b1;
                lp   = (w.r.opcode == op_beqz) ? (a == '0) : (a != '0);
                addr = npc + sx16;
            end
            default: begin  // j, jal, jr, jalr
                wr   = (w.r.opcode == op_jal || w.r.opcode == op_jalr);
                flow = 1'b1;
                lp   = 1'b1;
                addr = (w.r.opcode == op_jr || w.r.opcode == op_jalr) ? a : npc + sx26;
                res  = npc;
                dst  = 5'd31;
            end
        endcase
        if (wr && dst != 5'd0)
            model_regs[dst] = res;
        exp_result.push_back(res);
        exp_addr.push_back(addr);
        exp_dest.push_back(dst);
        exp_leap.push_back(lp);
        exp_flow.push_back(flow);
        exp_write.push_back(wr);
    endfunction

    function automatic void push_instr(input instr_t w);
        logic [0:31] pc;
        pc = 32'h0000_1000 + 32'(prog.size()) * 4;
        prog.push_back(w);
        npcs.push_back(pc + 4);
        gaps.push_back((($random(seed) & 7) == 0) ? 1 : 0);
        model_step(w, pc + 4);
    endfunction

    task automatic build_program();
        funct_t      fn_list [0:9];
        logic [0:31] v;
        int          fi, rd, ra, rb;
        fn_list = '{fn_add, fn_sub, fn_and, fn_or, fn_xor,
                    fn_sll, fn_srl, fn_sra, fn_slt, fn_mul};
        for (int r = 0; r < 32; r++)
            model_regs[r] = '0;
        push_instr(iword(op_addi, 9, 0, 16'd16));
        for (int r = 1; r <= 6; r++) begin  // random operands, hi then lo half
            v = $random(seed);
            push_instr(iword(op_addi, 5'(r), 0, v[0:15]));
            push_instr(rword(fn_sll, 5'(r), 5'(r), 9));
            push_instr(iword(op_ori, 5'(r), 5'(r), {1'b0, v[17:31]}));
        end
        push_instr(rword(fn_add, 10, 1, 2));
        push_instr(rword(fn_sub, 11, 1, 2));
        push_instr(rword(fn_and, 12, 3, 4));
        push_instr(rword(fn_or, 13, 3, 4));
        push_instr(rword(fn_xor, 14, 5, 6));
        push_instr(rword(fn_sll, 15, 1, 5));
        push_instr(rword(fn_srl, 16, 2, 5));
        push_instr(rword(fn_sra, 17, 3, 6));
        push_instr(rword(fn_slt, 18, 1, 2));
        push_instr(rword(fn_slt, 19, 2, 1));
        push_instr(rword(fn_mul, 20, 1, 2));
        push_instr(iword(op_addi, 21, 10, 16'hfffb));
        push_instr(iword(op_andi, 22, 1, 16'h8f0f));
        push_instr(iword(op_ori, 23, 2, 16'h1234));
        push_instr(iword(op_xori, 24, 3, 16'hf00f));
        push_instr(iword(op_slti, 25, 4, 16'hffff));
        push_instr(iword(op_slti, 26, 0, 16'h0001));
        push_instr(rword(fn_add, 27, 21, 22));     // reads back written registers
        push_instr(rword(fn_sub, 28, 1, 1));
        push_instr(iword(op_beqz, 0, 28, 16'h0040));
        push_instr(iword(op_beqz, 0, 1, 16'hff80));
        push_instr(iword(op_bnez, 0, 1, 16'hff80));
        push_instr(iword(op_bnez, 0, 28, 16'h0010));
        push_instr(jword(op_j, 26'h0000100));
        push_instr(jword(op_j, 26'h3ffffc0));      // backward jump
        push_instr(jword(op_jal, 26'h0000200));
        push_instr(rword(fn_add, 29, 31, 0));
        push_instr(iword(op_jr, 0, 10, 16'h0000));
        push_instr(iword(op_jalr, 0, 2, 16'h0000));
        push_instr(iword(op_jr, 0, 31, 16'h0000));
        for (int k = 0; k < 24; k++) begin
            fi = $unsigned($random(seed)) % 10;
            rd = 10 + $unsigned($random(seed)) % 16;
            ra = 1 + $unsigned($random(seed)) % 25;
            rb = 1 + $unsigned($random(seed)) % 25;
            push_instr(rword(fn_list[fi], 5'(rd), 5'(ra), 5'(rb)));
        end
        prog_len = prog.size();
    endtask

    task automatic report_mismatch(input string field, input logic [0:31] got,
                                   input logic [0:31] want);
        errors++;
        $display("FAILED at %0t ns: %s is %h, expected %h", $time, field, got, want);
    endtask

    task automatic check_result();
        logic [0:31] e_result, e_addr;
        logic [0:4]  e_dest;
        logic        e_leap, e_flow, e_write;
        if (exp_leap.size() == 0) begin
            errors++;
            $display("FAILED at %0t ns: result transferred with nothing outstanding", $time);
        end else begin
            e_result = exp_result.pop_front();
            e_addr   = exp_addr.pop_front();
            e_dest   = exp_dest.pop_front();
            e_leap   = exp_leap.pop_front();
            e_flow   = exp_flow.pop_front();
            e_write  = exp_write.pop_front();
            received++;
            assert (leap === e_leap) else report_mismatch("leap", leap, e_leap);
            assert (reg_write === e_write) else report_mismatch("reg_write", reg_write, e_write);
            if (e_write) begin
                assert (dest_reg === e_dest) else report_mismatch("dest_reg", dest_reg, e_dest);
                assert (alu_result === e_result)
                    else report_mismatch("alu_result", alu_result, e_result);
            end
            if (e_flow)
                assert (leap_addr === e_addr) else report_mismatch("leap_addr", leap_addr, e_addr);
        end
    endtask

    // outputs are stable at the falling edge, the transfer happens on the next rise
    always @(negedge clk) begin
        if (rst_n && res_valid && res_ready)
            check_result();
    end

    task automatic issue_instr(input instr_t w, input logic [0:31] pc);
        logic taken;
        in_valid = 1'b1;
        instr    = w;
        next_pc  = pc;
        taken    = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = in_ready;
            @(posedge clk);
            #1;
        end
    endtask

    initial begin : backpressure
        int phase;
        res_ready = 1'b0;
        phase     = 0;
        @(posedge rst_n);
        forever begin
            @(posedge clk);
            #1;
            phase++;
            if ((phase / 16) % 2 == 1)
                res_ready = ($random(seed) & 3) != 0;   // drops about one in four
            else
                res_ready = 1'b1;
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        wait (prog_len > 0);
        while (cycles < 20 * prog_len + 100) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: results still missing after %0d cycles", cycles);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        errors   = 0;
        received = 0;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        instr    = '0;
        next_pc  = '0;
        build_program();
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        assert (!in_ready && !res_valid && !leap && !reg_write) else begin
            errors++;
            $display("FAILED at %0t ns: outputs active after reset with no input", $time);
        end
        @(posedge clk);
        #1;
        for (int n = 0; n < prog_len; n++) begin
            if (gaps[n] != 0) begin
                in_valid = 1'b0;
                @(posedge clk);
                #1;
            end
            issue_instr(prog[n], npcs[n]);
        end
        in_valid = 1'b0;
        while (received < prog_len)
            @(posedge clk);
        repeat (5) @(posedge clk);
        assert (!res_valid) else begin
            errors++;
            $display("FAILED at %0t ns: extra result after the last instruction", $time);
        end
        $display("%0d value errors, %0d assertion failures, %0d results checked",
                 errors, uut.sva_chk.fail_count, received);
        if (errors == 0 && uut.sva_chk.fail_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
